// ==== permutationSum.f ====
rtl/permDomainPkg.sv
rtl/permLinkPkg.sv
rtl/batchController.sv
rtl/permIndexCounter.sv
rtl/variableSwapper.sv
rtl/coefficientAccumulator.sv
rtl/permutationSumTop.sv
verif/permutationSum_properties.sv
verif/permutationSumTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= permutationSumTb
FILELIST ?= permutationSum.f
BUILD_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Done: no errors

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/permutationSumTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module permutationSumTb
    import permDomainPkg::*;
    import permLinkPkg::*;
();

    localparam int testCount = 6;
    localparam int cyclesPerTest = 200;

    logic clk;
    logic rst;
    logic inReq;
    inputWord_u inWord;
    logic outAck;
    logic inAck;
    logic outReq;
    batchResult_t result;

    logic [31:0] lfsrState = 32'hbd96;
    logic [tableWidth-1:0] modelTop;
    logic [sumWidth-1:0] expSum;
    logic [countWidth-1:0] expCount;

    permutationSumTop i_dut (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inWord(inWord),
        .outAck(outAck),
        .inAck(inAck),
        .outReq(outReq),
        .result(result)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r[i] = lfsrState[0];
        end
        return r;
    endfunction

    function automatic logic [tableWidth-1:0] randomTable();
        return tableWidth'(randomBits(tableWidth));
    endfunction

    // Bit i of the result reads bit j, where j is i with index bits 0 and k exchanged
    function automatic logic [tableWidth-1:0] swappedTable(input logic [tableWidth-1:0] t,
                                                           input int k);
        logic [tableWidth-1:0] r;
        int b0;
        int bk;
        int j;
        for (int i = 0; i < tableWidth; i++) begin
            b0 = i & 1;
            bk = (i >> k) & 1;
            j = (i & ~(1 | (1 << k))) | bk | (b0 << k);
            r[i] = t[j];
        end
        return r;
    endfunction

    task automatic modelBot(input logic [tableWidth-1:0] bot);
        logic [tableWidth-1:0] p;
        for (int k = 0; k < permCount; k++) begin
            p = swappedTable(bot, k);
            if ((p & ~modelTop) == '0) begin
                expSum = expSum + sumWidth'($countones(p));
                expCount = expCount + 10'd1;
            end
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic sendWord(input inputWord_u w);
        @(posedge clk);
        inWord <= w;
        inReq <= 1'b1;
        do @(posedge clk); while (!inAck);
        inReq <= 1'b0;
        do @(posedge clk); while (inAck);
    endtask

    task automatic sendTop(input logic [tableWidth-1:0] t);
        inputWord_u w;
        w.top.kind = kindTop;
        w.top.reserved = 2'b00;
        w.top.topTable = t;
        modelTop = t;
        sendWord(w);
    endtask

    task automatic sendBot(input logic [tableWidth-1:0] t, input logic endOfBatch);
        inputWord_u w;
        w.bot.kind = kindBot;
        w.bot.endOfBatch = endOfBatch;
        w.bot.pad = 1'b0;
        w.bot.truthTable = t;
        sendWord(w);
    endtask

    // Result is held from outReq rising until outAck falls
    task automatic collectResult(input int delay, output batchResult_t got);
        do @(posedge clk); while (!outReq);
        got = result;
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
        @(posedge clk);
        outAck <= 1'b0;
        do @(posedge clk); while (outReq);
    endtask

    task automatic finishBatch(input int delay);
        batchResult_t got;
        collectResult(delay, got);
        checkValue("pcoeffSum", 32'(got.pcoeffSum), 32'(expSum));
        checkValue("pcoeffCount", 32'(got.pcoeffCount), 32'(expCount));
        expSum = '0;
        expCount = '0;
    endtask

    task automatic testReset();
        logic [tableWidth-1:0] bot;
        @(posedge clk);
        checkValue("inAck", 32'(inAck), 32'd0);
        checkValue("outReq", 32'(outReq), 32'd0);
        checkValue("pcoeffSum", 32'(result.pcoeffSum), 32'd0);
        checkValue("pcoeffCount", 32'(result.pcoeffCount), 32'd0);
        // Top is still all zeros here
        bot = randomTable() & randomTable();
        sendBot(bot, 1'b1);
        modelBot(bot);
        finishBatch(0);
    endtask

    task automatic testFullTop();
        logic [tableWidth-1:0] bot;
        batchResult_t got;
        sendTop(16'hffff);
        bot = randomTable();
        sendBot(bot, 1'b1);
        collectResult(0, got);
        // Swaps only move bits around
        checkValue("pcoeffCount", 32'(got.pcoeffCount), 32'd4);
        checkValue("pcoeffSum", 32'(got.pcoeffSum), 32'(4 * $countones(bot)));
    endtask

    task automatic testSubsetCheck();
        // Top excludes x3, so swaps that move a set bit into x3 fall out
        sendTop(16'h00ff);
        sendBot(16'h000f, 1'b0);
        modelBot(16'h000f);
        sendBot(16'h0101, 1'b1);
        modelBot(16'h0101);
        finishBatch(1);
    endtask

    task automatic testRandomBatches();
        int len;
        logic [tableWidth-1:0] bot;
        for (int batch = 0; batch < 6; batch++) begin
            // Dense tops and sparse bots so some permutations pass
            sendTop(randomTable() | randomTable());
            len = int'(randomBits(3) % 32'd5) + 1;
            for (int n = 0; n < len; n++) begin
                bot = randomTable() & randomTable();
                sendBot(bot, n == len - 1);
                modelBot(bot);
            end
            finishBatch(batch % 3);
        end
    endtask

    task automatic testBackPressure();
        logic [tableWidth-1:0] firstBot;
        logic [tableWidth-1:0] secondBot;
        logic [sumWidth-1:0] wantSum;
        logic [countWidth-1:0] wantCount;
        batchResult_t got;
        logic outputDone;
        outputDone = 1'b0;
        firstBot = randomTable() & randomTable();
        secondBot = randomTable() & randomTable();
        sendTop(randomTable() | randomTable());
        sendBot(firstBot, 1'b1);
        modelBot(firstBot);
        wantSum = expSum;
        wantCount = expCount;
        expSum = '0;
        expCount = '0;
        modelBot(secondBot);
        fork
            begin
                collectResult(40, got);
                outputDone = 1'b1;
            end
            begin
                sendBot(secondBot, 1'b1);
            end
            begin
                // Next word must wait for the pending result
                while (!outputDone) begin
                    @(posedge clk);
                    if (!outputDone) begin
                        checkValue("inAck", 32'(inAck), 32'd0);
                    end
                end
            end
        join
        checkValue("pcoeffSum", 32'(got.pcoeffSum), 32'(wantSum));
        checkValue("pcoeffCount", 32'(got.pcoeffCount), 32'(wantCount));
        finishBatch(0);
    endtask

    task automatic testTopReload();
        logic [tableWidth-1:0] bot;
        bot = randomTable() & randomTable();
        sendTop(randomTable() | randomTable());
        sendBot(bot, 1'b1);
        modelBot(bot);
        finishBatch(2);
        sendTop(randomTable() | randomTable());
        sendBot(bot, 1'b1);
        modelBot(bot);
        finishBatch(0);
    endtask

    initial begin
        rst = 1'b1;
        inReq = 1'b0;
        outAck = 1'b0;
        inWord = '0;
        modelTop = '0;
        expSum = '0;
        expCount = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testFullTop();
        testSubsetCheck();
        testRandomBatches();
        testBackPressure();
        testTopReload();
        $display("Done: no errors");
        $finish;
    end

    // A failed handshake assertion ends the run at once
    initial begin
        wait (i_dut.i_properties.failCount != 0);
        $display("A handshake assertion failed");
        $display("Done: errors found");
        $fatal(1, "Assertion failure");
    end

    initial begin
        repeat (testCount * cyclesPerTest) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== verif/permutationSum_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module permutationSum_properties
    import permLinkPkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic inReq,
    input wire logic inAck,
    input wire logic outReq,
    input wire logic outAck,
    input wire batchResult_t result,
    input wire ctrlState_e state
);

    // Running count of failed assertions
    int unsigned failCount = 0;

    // Ack answers a live request, right after the idle state took it
    assert property (@(posedge clk) disable iff (rst)
        $rose(inAck) |-> inReq && state == stAccept)
        else begin
            failCount = failCount + 1;
            $error("inAck rose without a pending inReq");
        end

    // Request holds until the host has acknowledged it
    assert property (@(posedge clk) disable iff (rst)
        outReq && !outAck && !$past(outAck) |=> outReq)
        else begin
            failCount = failCount + 1;
            $error("outReq dropped before outAck");
        end

    assert property (@(posedge clk) disable iff (rst)
        outReq |=> !outReq || $stable(result))
        else begin
            failCount = failCount + 1;
            $error("result changed while outReq was high");
        end

    // The two links never start a transfer together
    assert property (@(posedge clk) disable iff (rst)
        !($rose(inAck) && $rose(outReq)))
        else begin
            failCount = failCount + 1;
            $error("inAck and outReq rose together");
        end

endmodule

bind permutationSumTop permutationSum_properties i_properties (
    .clk(clk),
    .rst(rst),
    .inReq(inReq),
    .inAck(inAck),
    .outReq(outReq),
    .outAck(outAck),
    .result(result),
    .state(i_batchController.state)
);

`default_nettype wire

// ==== rtl/permutationSumTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module permutationSumTop
    import permDomainPkg::*;
    import permLinkPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic inReq,
    input  inputWord_u inWord,
    input  wire logic outAck,
    output logic inAck,
    output logic outReq,
    output batchResult_t result
);

    logic loadTop;
    logic loadBot;
    logic start;
    logic batchEnd;
    logic clear;
    logic busy;
    logic [permIndexWidth-1:0] permIndex;
    permItem_t item;

    batchController i_batchController (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inWord(inWord),
        .busy(busy),
        .outAck(outAck),
        .inAck(inAck),
        .loadTop(loadTop),
        .loadBot(loadBot),
        .start(start),
        .batchEnd(batchEnd),
        .clear(clear),
        .outReq(outReq)
    );

    permIndexCounter i_permIndexCounter (
        .clk(clk),
        .rst(rst),
        .start(start),
        .permIndex(permIndex),
        .busy(busy)
    );

    // Table field read through whichever view matches the load
    variableSwapper i_variableSwapper (
        .clk(clk),
        .rst(rst),
        .loadBot(loadBot),
        .botTable(inWord.bot.truthTable),
        .permIndex(permIndex),
        .busy(busy),
        .batchEnd(batchEnd),
        .item(item)
    );

    coefficientAccumulator i_coefficientAccumulator (
        .clk(clk),
        .rst(rst),
        .loadTop(loadTop),
        .topTable(inWord.top.topTable),
        .item(item),
        .clear(clear),
        .result(result)
    );

endmodule

`default_nettype wire

// ==== rtl/coefficientAccumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module coefficientAccumulator
    import permDomainPkg::*;
    import permLinkPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic loadTop,
    input  wire logic [tableWidth-1:0] topTable,
    input  permItem_t item,
    input  wire logic clear,
    output batchResult_t result
);

    logic [tableWidth-1:0] topReg;
    logic [sumWidth-1:0] sumReg;
    logic [countWidth-1:0] countReg;
    logic [sumWidth-1:0] onesCount;
    logic fitsTop;

    // Valid only when no set bit falls outside the top
    assign fitsTop = ((item.permTable & ~topReg) == '0);

    always_comb begin
        onesCount = '0;
        for (int i = 0; i < tableWidth; i++) begin
            onesCount = onesCount + sumWidth'(item.permTable[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            topReg <= '0;
        end else if (loadTop) begin
            topReg <= topTable;
        end
    end

    // Sum and count wrap at their own widths
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sumReg <= '0;
            countReg <= '0;
        end else if (item.valid && fitsTop) begin
            sumReg <= sumReg + onesCount;
            countReg <= countReg + 1'b1;
        end
    end

    assign result = '{pcoeffSum: sumReg, pcoeffCount: countReg};

endmodule

`default_nettype wire

// ==== rtl/variableSwapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module variableSwapper
    import permDomainPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic loadBot,
    input  wire logic [tableWidth-1:0] botTable,
    input  wire logic [permIndexWidth-1:0] permIndex,
    input  wire logic busy,
    input  wire logic batchEnd,
    output permItem_t item
);

    logic [tableWidth-1:0] botReg;
    logic [tableWidth-1:0] permTableReg;
    logic validReg;
    logic lastReg;

    // Output bit i reads the bot at i with index bits 0 and k exchanged
    function automatic logic [tableWidth-1:0] swapVars(
        input logic [tableWidth-1:0] t,
        input logic [permIndexWidth-1:0] k
    );
        logic [tableWidth-1:0] r;
        logic [varCount-1:0] idx;
        logic [varCount-1:0] src;
        for (int i = 0; i < tableWidth; i++) begin
            idx = varCount'(i);
            src = idx;
            src[0] = idx[k];
            src[k] = idx[0];
            r[i] = t[src];
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (loadBot) begin
            botReg <= botTable;
        end
        if (busy) begin
            permTableReg <= swapVars(botReg, permIndex);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validReg <= 1'b0;
            lastReg <= 1'b0;
        end else begin
            validReg <= busy;
            lastReg <= busy && batchEnd && (permIndex == permIndexWidth'(permCount - 1));
        end
    end

    assign item = '{permTable: permTableReg, valid: validReg, lastOfBatch: lastReg};

endmodule

`default_nettype wire

// ==== rtl/permIndexCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module permIndexCounter
    import permDomainPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    output logic [permIndexWidth-1:0] permIndex,
    output logic busy
);

    always_ff @(posedge clk) begin
        if (rst) begin
            permIndex <= '0;
            busy <= 1'b0;
        end else if (busy) begin
            if (permIndex == permIndexWidth'(permCount - 1)) begin
                busy <= 1'b0;
                permIndex <= '0;
            end else begin
                permIndex <= permIndex + 1'b1;
            end
        end else if (start) begin
            // A start during a run is dropped
            busy <= 1'b1;
            permIndex <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/batchController.sv ====
`timescale 1ns/1ps
`default_nettype none

module batchController
    import permDomainPkg::*;
    import permLinkPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic inReq,
    input  inputWord_u inWord,
    input  wire logic busy,
    input  wire logic outAck,
    output logic inAck,
    output logic loadTop,
    output logic loadBot,
    output logic start,
    output logic batchEnd,
    output logic clear,
    output logic outReq
);

    ctrlState_e state;
    logic acceptedBot;
    logic drainCount;
    logic wordIsBot;

    // Kind occupies the same bits in both views of the word
    assign wordIsBot = (inWord.bot.kind == kindBot);

    // Loads happen on the same edge that raises inAck
    assign loadTop = (state == stIdle) && inReq && !wordIsBot;
    assign loadBot = (state == stIdle) && inReq && wordIsBot;
    assign start = loadBot;

    // Accumulators clear as the host finishes the result handshake
    assign clear = (state == stRelease) && !outAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            inAck <= 1'b0;
            outReq <= 1'b0;
            batchEnd <= 1'b0;
            acceptedBot <= 1'b0;
            drainCount <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (inReq) begin
                        inAck <= 1'b1;
                        acceptedBot <= wordIsBot;
                        if (wordIsBot) begin
                            batchEnd <= inWord.bot.endOfBatch;
                        end
                        state <= stAccept;
                    end
                end
                stAccept: begin
                    // Finish the four-phase cycle before moving on
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= acceptedBot ? stRun : stIdle;
                    end
                end
                stRun: begin
                    if (!busy) begin
                        drainCount <= 1'b0;
                        state <= batchEnd ? stDrain : stIdle;
                    end
                end
                stDrain: begin
                    // Two cycles for the swapper and accumulator stages
                    drainCount <= 1'b1;
                    if (drainCount) begin
                        state <= stPublish;
                    end
                end
                stPublish: begin
                    outReq <= 1'b1;
                    if (outReq && outAck) begin
                        state <= stRelease;
                    end
                end
                stRelease: begin
                    if (!outAck) begin
                        outReq <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/permLinkPkg.sv ====
`default_nettype none

package permLinkPkg;

    // Both accumulators wrap at their width
    localparam int sumWidth = 16;
    localparam int countWidth = 10;

    typedef struct packed {
        logic [sumWidth-1:0] pcoeffSum;
        logic [countWidth-1:0] pcoeffCount;
    } batchResult_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        stIdle = 3'd0,
        stAccept = 3'd1,
        stRun = 3'd2,
        stDrain = 3'd3,
        stPublish = 3'd4,
        stRelease = 3'd5
    } ctrlState_e;

endpackage

`default_nettype wire

// ==== rtl/permDomainPkg.sv ====
`default_nettype none

package permDomainPkg;

    // 4-variable functions, one bit per input combination
    localparam int tableWidth = 16;
    localparam int varCount = 4;

    // Permutation k swaps variable 0 with variable k
    localparam int permCount = 4;
    localparam int permIndexWidth = 2;

    typedef enum logic [1:0] {
        kindTop = 2'd0,
        kindBot = 2'd1
    } wordKind_e;

    typedef struct packed {
        wordKind_e kind;
        logic endOfBatch;
        logic pad;
        logic [tableWidth-1:0] truthTable;
    } botWord_t;

    typedef struct packed {
        wordKind_e kind;
        logic [1:0] reserved;
        logic [tableWidth-1:0] topTable;
    } topWord_t;

    // Kind sits in the top two bits of both views
    typedef union packed {
        botWord_t bot;
        topWord_t top;
    } inputWord_u;

    typedef struct packed {
        logic [tableWidth-1:0] permTable;
        logic valid;
        logic lastOfBatch;
    } permItem_t;

endpackage

`default_nettype wire
